// File: hw/shell_pkg.sv
package shell_pkg;

	localparam int rom_aw_default  = 15;	// byte address, 32 KiB
	localparam int audio_w_default = 16;

	// PS/2 set 2 scancodes
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6b;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76;	// esc
	localparam logic [7:0] key_start1 = 8'h05;	// f1
	localparam logic [7:0] key_start2 = 8'h06;	// f2
	localparam logic [7:0] key_fire   = 8'h29;	// space

	// Button vector, bit 0 first: up, down, left, right, fire, coin, start1, start2.
	// Joystick bits 3, 2, 1, 0 and 4 feed up, down, left, right and fire.
	localparam int btn_w          = 8;
	localparam int btn_up_bit     = 0;
	localparam int btn_down_bit   = 1;
	localparam int btn_left_bit   = 2;
	localparam int btn_right_bit  = 3;
	localparam int btn_fire_bit   = 4;
	localparam int btn_coin_bit   = 5;
	localparam int btn_start1_bit = 6;
	localparam int btn_start2_bit = 7;

endpackage

// File: hw/rom_loader.sv
module rom_loader
	import shell_pkg::*;
#(
	parameter int ROM_AW = rom_aw_default
) (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  logic              ioctl_download,
	input  logic              ioctl_wr,
	input  logic [ROM_AW-1:0] ioctl_addr,
	input  logic [7:0]        ioctl_dout,
	output logic              wr_en,
	output logic [ROM_AW-2:0] wr_addr,
	output logic [1:0]        wr_lane,
	output logic [15:0]       wr_data
);

	logic wr_last;
	logic wr_rise;

	assign wr_rise = ioctl_download & ioctl_wr & ~wr_last;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_last <= 1'b0;
			wr_en   <= 1'b0;
		end else begin
			wr_last <= ioctl_wr;
			wr_en   <= wr_rise;	// single pulse per byte
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_rise) begin
			wr_addr <= ioctl_addr[ROM_AW-1:1];
			wr_lane <= {ioctl_addr[0], ~ioctl_addr[0]};	// odd byte -> upper lane
			wr_data <= {ioctl_dout, ioctl_dout};
		end
	end

	// a write always enables at least one byte lane
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		wr_en |-> (wr_lane != 2'b00))
		else $error("rom_loader: write pulse with empty lane mask");

endmodule

// File: hw/rom_store.sv
module rom_store
	import shell_pkg::*;
#(
	parameter int ROM_AW = rom_aw_default
) (
	input  logic              sys_clk,
	input  logic              wr_en,
	input  logic [ROM_AW-2:0] wr_addr,
	input  logic [1:0]        wr_lane,
	input  logic [15:0]       wr_data,
	input  logic [ROM_AW-1:0] rd_addr,
	output logic [7:0]        rd_data
);

	localparam int depth = 2 ** (ROM_AW - 1);

	logic [15:0] mem [depth];
	logic [15:0] rd_word;
	logic        rd_odd;

	always_ff @(posedge sys_clk) begin
		if (wr_en && wr_lane[0])
			mem[wr_addr][7:0] <= wr_data[7:0];
		if (wr_en && wr_lane[1])
			mem[wr_addr][15:8] <= wr_data[15:8];
	end

	always_ff @(posedge sys_clk) begin
		rd_word <= mem[rd_addr[ROM_AW-1:1]];
		rd_odd  <= rd_addr[0];	// byte select follows the word
	end

	assign rd_data = rd_odd ? rd_word[15:8] : rd_word[7:0];

	// lane mask from the loader must be resolved when it writes
	assert property (@(posedge sys_clk)
		wr_en |-> !$isunknown(wr_lane))
		else $error("rom_store: unknown lane mask during write");

endmodule

// File: hw/reset_ctrl.sv
module reset_ctrl (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic ioctl_download,
	input  logic status_reset,
	input  logic button_reset,
	output logic core_reset
);

	logic download_q;
	logic rom_loaded;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			download_q <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_q <= ioctl_download;
			if (download_q && !ioctl_download)
				rom_loaded <= 1'b1;	// sticky until rst_n
			core_reset <= status_reset | button_reset | ~rom_loaded;
		end
	end

	// the core never runs without a ROM
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		!rom_loaded |-> core_reset)
		else $error("reset_ctrl: core released before ROM load");

endmodule

// File: hw/key_mapper.sv
module key_mapper
	import shell_pkg::*;
(
	input  logic             sys_clk,
	input  logic             rst_n,
	input  logic             key_strobe,
	input  logic             key_pressed,
	input  logic [7:0]       key_code,
	input  logic [7:0]       joystick_0,
	input  logic [7:0]       joystick_1,
	output logic [btn_w-1:0] buttons
);

	logic [btn_w-1:0] key_btn;
	logic [7:0]       joy;
	logic [btn_w-1:0] joy_btn;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			key_btn <= '0;
		end else if (key_strobe) begin
			case (key_code)
				key_up:     key_btn[btn_up_bit]     <= key_pressed;
				key_down:   key_btn[btn_down_bit]   <= key_pressed;
				key_left:   key_btn[btn_left_bit]   <= key_pressed;
				key_right:  key_btn[btn_right_bit]  <= key_pressed;
				key_fire:   key_btn[btn_fire_bit]   <= key_pressed;
				key_coin:   key_btn[btn_coin_bit]   <= key_pressed;
				key_start1: key_btn[btn_start1_bit] <= key_pressed;
				key_start2: key_btn[btn_start2_bit] <= key_pressed;
				default:    ;	// other keys ignored
			endcase
		end
	end

	assign joy = joystick_0 | joystick_1;	// both players share one set

	always_comb begin
		joy_btn                 = '0;
		joy_btn[btn_up_bit]     = joy[3];
		joy_btn[btn_down_bit]   = joy[2];
		joy_btn[btn_left_bit]   = joy[1];
		joy_btn[btn_right_bit]  = joy[0];
		joy_btn[btn_fire_bit]   = joy[4];
	end

	assign buttons = key_btn | joy_btn;

endmodule

// File: hw/sd_dac.sv
module sd_dac
	import shell_pkg::*;
#(
	parameter int AUDIO_W = audio_w_default
) (
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic [AUDIO_W-1:0] audio_in,
	output logic               audio_out
);

	logic [AUDIO_W:0] acc;

	// first order: keep the residue, carry out is the bit
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[AUDIO_W-1:0]} + {1'b0, audio_in};
	end

	assign audio_out = acc[AUDIO_W];

endmodule

// File: hw/video_out.sv
module video_out (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       tv15khz_mode,
	input  logic [2:0] core_r,
	input  logic [2:0] core_g,
	input  logic [1:0] core_b,
	input  logic       core_blankn,
	input  logic       core_hs,
	input  logic       core_vs,
	input  logic       core_csync,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic [2:0] blue3;

	assign blue3 = {core_b, core_b[1]};

	always_ff @(posedge sys_clk) begin
		if (!core_blankn) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			vga_r <= {core_r, core_r};	// repeat to fill 6 bits
			vga_g <= {core_g, core_g};
			vga_b <= {blue3, blue3};
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (tv15khz_mode) begin
			vga_hs <= core_csync;	// composite on hs pin
			vga_vs <= 1'b1;
		end else begin
			vga_hs <= core_hs;
			vga_vs <= core_vs;
		end
	end

endmodule

// File: hw/arcade_shell_top.sv
module arcade_shell_top
	import shell_pkg::*;
#(
	parameter int ROM_AW  = rom_aw_default,
	parameter int AUDIO_W = audio_w_default
) (
	input  logic               sys_clk,
	input  logic               rst_n,
	input  logic               ioctl_download,
	input  logic               ioctl_wr,
	input  logic [ROM_AW-1:0]  ioctl_addr,
	input  logic [7:0]         ioctl_dout,
	input  logic               status_reset,
	input  logic               button_reset,
	input  logic               key_strobe,
	input  logic               key_pressed,
	input  logic [7:0]         key_code,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic               tv15khz_mode,
	input  logic [ROM_AW-1:0]  cpu_rom_addr,
	output logic [7:0]         cpu_rom_do,
	input  logic [AUDIO_W-1:0] audio_in,
	output logic               audio_l,
	output logic               audio_r,
	input  logic [2:0]         core_r,
	input  logic [2:0]         core_g,
	input  logic [1:0]         core_b,
	input  logic               core_blankn,
	input  logic               core_hs,
	input  logic               core_vs,
	input  logic               core_csync,
	output logic [5:0]         vga_r,
	output logic [5:0]         vga_g,
	output logic [5:0]         vga_b,
	output logic               vga_hs,
	output logic               vga_vs,
	output logic [btn_w-1:0]   buttons,
	output logic               core_reset,
	output logic               led
);

	logic              wr_en;
	logic [ROM_AW-2:0] wr_addr;
	logic [1:0]        wr_lane;
	logic [15:0]       wr_data;

	assign led     = ~ioctl_download;	// lit while idle
	assign audio_r = audio_l;

	rom_loader #(.ROM_AW(ROM_AW)) u_rom_loader (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_lane(wr_lane), .wr_data(wr_data)
	);

	rom_store #(.ROM_AW(ROM_AW)) u_rom_store (
		.sys_clk(sys_clk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_lane(wr_lane), .wr_data(wr_data),
		.rd_addr(cpu_rom_addr), .rd_data(cpu_rom_do)
	);

	reset_ctrl u_reset_ctrl (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.ioctl_download(ioctl_download),
		.status_reset(status_reset), .button_reset(button_reset),
		.core_reset(core_reset)
	);

	key_mapper u_key_mapper (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.buttons(buttons)
	);

	sd_dac #(.AUDIO_W(AUDIO_W)) u_sd_dac (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.audio_in(audio_in), .audio_out(audio_l)
	);

	video_out u_video_out (
		.sys_clk(sys_clk), .rst_n(rst_n), .tv15khz_mode(tv15khz_mode),
		.core_r(core_r), .core_g(core_g), .core_b(core_b), .core_blankn(core_blankn),
		.core_hs(core_hs), .core_vs(core_vs), .core_csync(core_csync),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
	);

endmodule

// File: testbench/arcade_shell_tb.sv
module arcade_shell_tb
	import shell_pkg::*;
();

	localparam int rom_aw          = 10;
	localparam int audio_w         = 16;
	localparam int rom_bytes       = 256;
	localparam int watchdog_cycles = 20000;	// about twice the whole run

	// scancodes in button bit order
	localparam logic [7:0] key_codes [btn_w] = '{key_up, key_down, key_left, key_right,
		key_fire, key_coin, key_start1, key_start2};

	logic               sys_clk;
	logic               rst_n;
	logic               ioctl_download, ioctl_wr;
	logic [rom_aw-1:0]  ioctl_addr, cpu_rom_addr;
	logic [7:0]         ioctl_dout, cpu_rom_do;
	logic               status_reset, button_reset, core_reset, led;
	logic               key_strobe, key_pressed;
	logic [7:0]         key_code, joystick_0, joystick_1;
	logic [btn_w-1:0]   buttons;
	logic [audio_w-1:0] audio_in;
	logic               audio_l, audio_r;
	logic [2:0]         core_r, core_g;
	logic [1:0]         core_b;
	logic               core_blankn, core_hs, core_vs, core_csync, tv15khz_mode;
	logic [5:0]         vga_r, vga_g, vga_b;
	logic               vga_hs, vga_vs;

	logic [7:0]         rom_model [2**rom_aw];
	logic [btn_w-1:0]   model_keys;
	logic [5:0]         exp_r, exp_g, exp_b;
	logic               exp_hs, exp_vs;
	logic               rd_phase, dl_done, release_due, video_on;
	logic               count_clr, count_en, window_end;
	int                 ones_count;

	arcade_shell_top #(.ROM_AW(rom_aw), .AUDIO_W(audio_w)) dut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	function automatic void report_mismatch(string msg);
		$display("** Error: %0t: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first failed check");
	endfunction

	// joystick bits 3 2 1 0 4 onto up down left right fire
	function automatic logic [btn_w-1:0] joy_expand(logic [7:0] joy);
		return {3'b000, joy[4], joy[0], joy[1], joy[2], joy[3]};
	endfunction

	function automatic logic [btn_w-1:0] key_mask(logic [7:0] code);
		logic [btn_w-1:0] m;
		m = '0;
		for (int i = 0; i < btn_w; i++)
			if (key_codes[3'(i)] == code)
				m = m | (btn_w'(1) << i);
		return m;
	endfunction

	task automatic next_cycle();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic strobe_key(logic [7:0] code, logic pressed);
		key_code    = code;
		key_pressed = pressed;
		key_strobe  = 1'b1;
		next_cycle();
		key_strobe  = 1'b0;
		next_cycle();
	endtask

	always @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			model_keys <= '0;
		else if (key_strobe)
			model_keys <= key_pressed ? (model_keys | key_mask(key_code))
				: (model_keys & ~key_mask(key_code));
	end

	always_comb begin
		exp_r  = core_blankn ? {core_r, core_r} : 6'd0;
		exp_g  = core_blankn ? {core_g, core_g} : 6'd0;
		exp_b  = core_blankn ? {2{core_b[1], core_b[0], core_b[1]}} : 6'd0;
		exp_hs = tv15khz_mode ? core_csync : core_hs;
		exp_vs = tv15khz_mode ? 1'b1 : core_vs;
	end

	always @(posedge sys_clk) begin
		if (count_clr)
			ones_count <= 0;
		else if (count_en)
			ones_count <= ones_count + (audio_l ? 1 : 0);
	end

	assert property (@(posedge sys_clk) disable iff (!rst_n)
		rd_phase |=> cpu_rom_do == rom_model[$past(cpu_rom_addr)])
		else report_mismatch($sformatf("cpu_rom_do %02h differs from loaded byte", cpu_rom_do));
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		!dl_done |-> core_reset)
		else report_mismatch("core_reset low before the download ended");
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		(release_due && !status_reset && !button_reset) |=> !core_reset)
		else report_mismatch("core_reset still high after ROM load");
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		(status_reset || button_reset) |=> core_reset)
		else report_mismatch("core_reset did not follow a reset request");
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		buttons == (model_keys | joy_expand(joystick_0 | joystick_1)))
		else report_mismatch($sformatf("buttons %08b, expected %08b", buttons,
			model_keys | joy_expand(joystick_0 | joystick_1)));
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		video_on |=> {vga_r, vga_g, vga_b} == $past({exp_r, exp_g, exp_b}))
		else report_mismatch($sformatf("colour %h %h %h", vga_r, vga_g, vga_b));
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		video_on |=> {vga_hs, vga_vs} == $past({exp_hs, exp_vs}))
		else report_mismatch($sformatf("sync hs %b vs %b", vga_hs, vga_vs));
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		window_end |-> ones_count >= int'(audio_in[audio_w-1 -: 10]) - 1
			&& ones_count <= int'(audio_in[audio_w-1 -: 10]) + 1)
		else report_mismatch($sformatf("%0d ones for sample %h", ones_count, audio_in));
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		audio_r == audio_l)
		else report_mismatch("audio_r differs from audio_l");
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		led == !ioctl_download)
		else report_mismatch($sformatf("led %b while ioctl_download %b", led,
			ioctl_download));

	initial begin
		logic [31:0] rnd;
		void'($urandom(32'h47));
		{ioctl_download, ioctl_wr, ioctl_addr, ioctl_dout, status_reset, button_reset,
			key_strobe, key_pressed, key_code, joystick_0, joystick_1, tv15khz_mode,
			cpu_rom_addr, audio_in, core_r, core_g, core_b, core_blankn, core_hs, core_vs,
			core_csync} = '0;
		{rd_phase, dl_done, release_due, video_on, count_clr, count_en, window_end} = '0;
		rst_n = 1'b0;
		repeat (16) @(posedge sys_clk);
		#1 rst_n = 1'b1;
		next_cycle();

		ioctl_download = 1'b1;
		for (int i = 0; i < rom_bytes; i++) begin
			rnd        = $urandom();
			ioctl_addr = rom_aw'(i);
			ioctl_dout = rnd[7:0];
			rom_model[ioctl_addr] = rnd[7:0];
			ioctl_wr   = 1'b1;
			next_cycle();
			ioctl_wr   = 1'b0;
			repeat (2 + int'(rnd[8])) next_cycle();	// 3 or 4 cycles per byte
		end
		ioctl_download = 1'b0;
		dl_done        = 1'b1;
		repeat (2) next_cycle();
		release_due    = 1'b1;

		rd_phase = 1'b1;
		for (int i = 0; i < rom_bytes; i++) begin
			cpu_rom_addr = rom_aw'(i);
			next_cycle();
		end
		rd_phase = 1'b0;

		status_reset = 1'b1;
		repeat (2) next_cycle();
		status_reset = 1'b0;
		button_reset = 1'b1;
		next_cycle();
		button_reset = 1'b0;
		repeat (2) next_cycle();

		for (int k = 0; k < btn_w; k++) begin
			strobe_key(key_codes[3'(k)], 1'b1);
			strobe_key(key_codes[3'(k)], 1'b0);
		end
		strobe_key(key_fire, 1'b1);
		strobe_key(8'h1c, 1'b1);	// unmapped key
		strobe_key(key_fire, 1'b0);
		for (int j = 0; j < 5; j++) begin
			joystick_0 = 8'(1 << j);
			joystick_1 = 8'(16 >> j);
			next_cycle();
		end
		{joystick_0, joystick_1} = '0;

		video_on = 1'b1;
		for (int v = 0; v < 400; v++) begin
			rnd = $urandom();
			{core_r, core_g, core_b, core_hs, core_vs, core_csync} = rnd[10:0];
			core_blankn  = |rnd[15:14];	// mostly visible
			tv15khz_mode = (v >= 200);
			next_cycle();
		end
		video_on = 1'b0;

		for (int s = 0; s < 6; s++) begin
			rnd       = $urandom();
			audio_in  = (s == 5) ? '1 : rnd[audio_w-1:0];
			count_clr = 1'b1;
			next_cycle();
			count_clr = 1'b0;
			count_en  = 1'b1;
			repeat (1024) next_cycle();
			count_en   = 1'b0;
			window_end = 1'b1;
			next_cycle();
			window_end = 1'b0;
		end

		repeat (4) next_cycle();
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge sys_clk);
		$display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
		$display("ERRORS FOUND");
		$fatal(1, "timeout");
	end

endmodule

// File: arcade_shell.f
hw/shell_pkg.sv
hw/rom_loader.sv
hw/rom_store.sv
hw/reset_ctrl.sv
hw/key_mapper.sv
hw/sd_dac.sv
hw/video_out.sv
hw/arcade_shell_top.sv
testbench/arcade_shell_tb.sv

// File: Makefile
TOP = arcade_shell_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f arcade_shell.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "ERRORS FOUND" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir sim.log
